// ==== dv/store_buffer_sva.sv ====
module store_buffer_sva (
	input logic clk_i,
	input logic rst_i,
	input logic cyc_i,
	input logic stb_i,
	input logic we_i,
	input store_pkg::bsel_t sel_i,
	input store_pkg::addr_t adr_i,
	input store_pkg::bdata_t dat_i,
	input logic ack_i,
	input logic err_i,
	input logic tlbmiss_i,
	input logic wrv_i,
	input logic full_i,
	input logic push_i
);
	timeunit 1ns;
	timeprecision 100ps;

	// number of assertion failures over the whole run
	int fail_count = 0;
	logic resp;

	// any of the four slave answers closes a beat
	assign resp = ack_i || err_i || tlbmiss_i || wrv_i;

	// ==============================
	// bus protocol
	// ==============================

	stb_in_cycle: assert property (@(posedge clk_i) disable iff (rst_i) stb_i |-> cyc_i)
		else begin
			$error("stb_o is high outside a bus cycle");
			fail_count++;
		end

	sel_not_empty: assert property (@(posedge clk_i) disable iff (rst_i) stb_i |-> sel_i != '0)
		else begin
			$error("a beat was strobed with no byte lane selected");
			fail_count++;
		end

	// a beat that has not been answered keeps its request unchanged
	hold_while_waiting: assert property (@(posedge clk_i) disable iff (rst_i)
		stb_i && !resp |=> stb_i && cyc_i && we_i && $stable(sel_i) && $stable(adr_i)
			&& $stable(dat_i))
		else begin
			$error("bus outputs changed while a beat was waiting for its answer");
			fail_count++;
		end

	// ==============================
	// queue
	// ==============================

	no_push_when_full: assert property (@(posedge clk_i) disable iff (rst_i)
		!(full_i && push_i))
		else begin
			$error("the write buffer was pushed while full");
			fail_count++;
		end

endmodule

bind store_buffer store_buffer_sva u_sva (
	.clk_i(clk_i),
	.rst_i(rst_i),
	.cyc_i(cyc_o),
	.stb_i(stb_o),
	.we_i(we_o),
	.sel_i(sel_o),
	.adr_i(adr_o),
	.dat_i(dat_o),
	.ack_i(ack_i),
	.err_i(err_i),
	.tlbmiss_i(tlbmiss_i),
	.wrv_i(wrv_i),
	.full_i(full),
	.push_i(push)
);

// ==== dv/store_buffer_tb.sv ====
module store_buffer_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import store_pkg::*;

	localparam int DEPTH = 7;
	// each test needs well under a few hundred cycles, so 5000 leaves a wide margin
	localparam int TIMEOUT_CYCLES = 5000;

	// one completion as seen at the update_o pulse
	typedef struct packed {
		tag_t tag;
		logic cwr;
		cache_wr_t wr;
		fault_e fault;
	} completion_t;

	logic clk_i;
	logic rst_i;
	logic p0_wr_i;
	store_req_t p0_req_i;
	logic p0_ack_o;
	logic p1_wr_i;
	store_req_t p1_req_i;
	logic p1_ack_o;
	addr_t p0_adr_i;
	addr_t p1_adr_i;
	logic p0_hit_o;
	logic p1_hit_o;
	logic wb_en_i;
	logic bus_busy_i;
	logic cyc_o;
	logic stb_o;
	logic we_o;
	bsel_t sel_o;
	addr_t adr_o;
	bdata_t dat_o;
	logic ack_i;
	logic err_i;
	logic tlbmiss_i;
	logic wrv_i;
	logic update_o;
	tag_t commit_tag_o;
	logic cwr_o;
	cache_wr_t cache_wr_o;
	fault_e fault_o;

	completion_t comp_q [$];
	completion_t seen_comp;
	store_req_t exp_q [$];
	addr_t beat_q [$];
	logic [7:0] bus_mem [addr_t];
	logic [7:0] ref_mem [addr_t];
	// 0 answers with ack, 1 with err_i, 2 with tlbmiss_i and 3 with wrv_i
	int inject_kind;
	int beat_wait;
	int beat_lat;
	int cycle_count;
	int errors;
	int tests_run;
	int tests_failed;

	store_buffer #(
		.DEPTH(DEPTH)
	) u_store_buffer (
		.*
	);

	initial begin
		clk_i = 1'b0;
		forever #50 clk_i = ~clk_i;
	end

	always @(posedge clk_i) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("run stopped after %0d cycles without finishing", cycle_count);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// ==============================
	// bus slave model
	// ==============================

	// a beat is answered 1 to 4 cycles after its strobe is first seen
	// while an answer is on the bus the still high strobe is not a new beat
	always @(posedge clk_i) begin
		if (rst_i) begin
			ack_i <= 1'b0;
			err_i <= 1'b0;
			tlbmiss_i <= 1'b0;
			wrv_i <= 1'b0;
			beat_wait = 0;
			beat_lat = $urandom_range(4, 1);
		end else begin
			ack_i <= 1'b0;
			err_i <= 1'b0;
			tlbmiss_i <= 1'b0;
			wrv_i <= 1'b0;
			if (stb_o && we_o && !(ack_i || err_i || tlbmiss_i || wrv_i)) begin
				beat_wait++;
				if (beat_wait >= beat_lat) begin
					beat_wait = 0;
					beat_lat = $urandom_range(4, 1);
					beat_q.push_back(adr_o);
					case (inject_kind)
						1: err_i <= 1'b1;
						2: tlbmiss_i <= 1'b1;
						3: wrv_i <= 1'b1;
						default: begin
							ack_i <= 1'b1;
							for (int b = 0; b < 16; b++) begin
								if (sel_o[b]) begin
									bus_mem[addr_t'(adr_o + b)] = dat_o[8 * b +: 8];
								end
							end
						end
					endcase
					// an injected error hits one beat only
					inject_kind = 0;
				end
			end
		end
	end

	// collects every completion for the tests to check in order
	always @(posedge clk_i) begin
		if (!rst_i && update_o) begin
			seen_comp = '{tag: commit_tag_o, cwr: cwr_o, wr: cache_wr_o, fault: fault_o};
			comp_q.push_back(seen_comp);
		end
		if (!rst_i) begin
			assert (!(cwr_o && !update_o)) else begin
				$display("cwr_o pulsed without update_o");
				errors++;
			end
		end
	end

	// ==============================
	// helpers
	// ==============================

	task automatic compare_hex(string name, logic [127:0] got, logic [127:0] exp);
		assert (got === exp) else begin
			$display("Mismatch %s: got %0h, expected %0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_true(bit cond, string what);
		assert (cond) else begin
			$display("%s", what);
			errors++;
		end
	endtask

	function automatic store_req_t new_store(tag_t tag, addr_t addr, ssel_t sel);
		store_req_t s;
		s.tag = tag;
		s.sel = sel;
		s.addr = addr;
		s.data = {$urandom, $urandom};
		return s;
	endfunction

	task automatic raise_request(int port, store_req_t s);
		if (port == 0) begin
			p0_wr_i <= 1'b1;
			p0_req_i <= s;
		end else begin
			p1_wr_i <= 1'b1;
			p1_req_i <= s;
		end
	endtask

	// the request drops at the edge where the ack is seen
	task automatic await_ack(int port, store_req_t s);
		bit seen;
		seen = 1'b0;
		while (!seen) begin
			@(posedge clk_i);
			seen = (port == 0) ? p0_ack_o : p1_ack_o;
		end
		if (port == 0) begin
			p0_wr_i <= 1'b0;
		end else begin
			p1_wr_i <= 1'b0;
		end
		exp_q.push_back(s);
	endtask

	task automatic no_ack_for(int port, int cycles);
		repeat (cycles) begin
			@(posedge clk_i);
			check_true((port == 0) ? !p0_ack_o : !p1_ack_o,
				$sformatf("port %0d was acked although the buffer could not take it", port));
		end
	endtask

	// compares the next completion against the oldest accepted store
	task automatic check_next_completion(bit exp_ok, fault_e exp_fault);
		completion_t c;
		store_req_t s;
		while (comp_q.size() == 0) begin
			@(posedge clk_i);
		end
		c = comp_q.pop_front();
		check_true(exp_q.size() > 0, "a store completed that was never accepted");
		if (exp_q.size() > 0) begin
			s = exp_q.pop_front();
			compare_hex("commit_tag_o", c.tag, s.tag);
			compare_hex("cwr_o", c.cwr, exp_ok);
			compare_hex("fault_o", c.fault, exp_fault);
			if (exp_ok) begin
				compare_hex("cache_wr_o.addr", c.wr.addr, s.addr);
				compare_hex("cache_wr_o.sel", c.wr.sel, s.sel);
				compare_hex("cache_wr_o.data", c.wr.data, s.data);
				// byte i of a store belongs at its address plus i
				for (int i = 0; i < 8; i++) begin
					if (s.sel[i]) begin
						ref_mem[addr_t'(s.addr + i)] = s.data[8 * i +: 8];
					end
				end
			end
		end
	endtask

	task automatic compare_memory();
		foreach (ref_mem[a]) begin
			check_true(bus_mem.exists(a), $sformatf("byte %h never reached the bus", a));
			if (bus_mem.exists(a)) begin
				compare_hex($sformatf("mem[%h]", a), bus_mem[a], ref_mem[a]);
			end
		end
	endtask

	task automatic close_test(string name, int err_before);
		tests_run++;
		if (errors != err_before) begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, errors - err_before);
		end else begin
			$display("test %s: ok", name);
		end
	endtask

	// ==============================
	// directed tests
	// ==============================

	task automatic test_aligned();
		store_req_t s;
		int err_before;
		err_before = errors;
		beat_q.delete();
		s = new_store(4'h1, 32'h0000_1008, 8'hff);
		@(posedge clk_i);
		raise_request(0, s);
		await_ack(0, s);
		check_next_completion(1'b1, FLT_NONE);
		compare_hex("beat count", beat_q.size(), 1);
		if (beat_q.size() > 0) begin
			compare_hex("adr_o", beat_q[0], 32'h0000_1000);
		end
		compare_memory();
		close_test("aligned store", err_before);
	endtask

	// offset 12 spills four bytes into the following line
	task automatic test_line_cross();
		store_req_t s;
		int err_before;
		err_before = errors;
		beat_q.delete();
		s = new_store(4'h2, 32'h0000_200c, 8'hff);
		@(posedge clk_i);
		raise_request(1, s);
		await_ack(1, s);
		check_next_completion(1'b1, FLT_NONE);
		compare_hex("beat count", beat_q.size(), 2);
		if (beat_q.size() == 2) begin
			compare_hex("adr_o", beat_q[0], 32'h0000_2000);
			compare_hex("adr_o", beat_q[1], 32'h0000_2010);
		end
		compare_memory();
		close_test("line-crossing store", err_before);
	endtask

	task automatic test_priority();
		store_req_t s0;
		store_req_t s1;
		bit got0;
		bit got1;
		int first_port;
		int err_before;
		err_before = errors;
		beat_q.delete();
		s0 = new_store(4'h3, 32'h0000_3004, 8'h3c);
		s1 = new_store(4'h4, 32'h0000_3100, 8'hff);
		got0 = 1'b0;
		got1 = 1'b0;
		first_port = -1;
		@(posedge clk_i);
		raise_request(0, s0);
		raise_request(1, s1);
		while (!(got0 && got1)) begin
			@(posedge clk_i);
			if (p0_ack_o && !got0) begin
				got0 = 1'b1;
				p0_wr_i <= 1'b0;
				exp_q.push_back(s0);
				if (first_port < 0) begin
					first_port = 0;
				end
			end
			if (p1_ack_o && !got1) begin
				got1 = 1'b1;
				p1_wr_i <= 1'b0;
				exp_q.push_back(s1);
				if (first_port < 0) begin
					first_port = 1;
				end
			end
		end
		compare_hex("first acked port", first_port, 0);
		check_next_completion(1'b1, FLT_NONE);
		check_next_completion(1'b1, FLT_NONE);
		compare_hex("beat count", beat_q.size(), 2);
		if (beat_q.size() == 2) begin
			compare_hex("adr_o", beat_q[0], 32'h0000_3000);
			compare_hex("adr_o", beat_q[1], 32'h0000_3100);
		end
		compare_memory();
		close_test("priority and ordering", err_before);
	endtask

	task automatic test_backpressure();
		store_req_t s;
		store_req_t extra;
		int err_before;
		err_before = errors;
		beat_q.delete();
		@(posedge clk_i);
		bus_busy_i <= 1'b1;
		// one store per line, alternating ports and line halves
		for (int i = 0; i < DEPTH; i++) begin
			s = new_store(tag_t'(i), addr_t'(32'h4000 + i * 16 + (i % 2) * 8),
				ssel_t'($urandom) | 8'h01);
			@(posedge clk_i);
			raise_request(i % 2, s);
			await_ack(i % 2, s);
		end
		extra = new_store(tag_t'(DEPTH), addr_t'(32'h4000 + DEPTH * 16), 8'hff);
		@(posedge clk_i);
		raise_request(0, extra);
		no_ack_for(0, 8);
		p0_adr_i <= 32'h0000_4032;
		p1_adr_i <= 32'h0000_5000;
		@(posedge clk_i);
		check_true(p0_hit_o, "no hit for a load to a buffered line");
		check_true(!p1_hit_o, "hit reported for a line with no buffered store");
		// the last buffered line is queried from the other port
		p1_adr_i <= 32'h0000_4064;
		@(posedge clk_i);
		check_true(p1_hit_o, "no hit on port 1 for a load to a buffered line");
		bus_busy_i <= 1'b0;
		await_ack(0, extra);
		for (int i = 0; i <= DEPTH; i++) begin
			check_next_completion(1'b1, FLT_NONE);
		end
		compare_hex("beat count", beat_q.size(), DEPTH + 1);
		for (int i = 0; i < beat_q.size() && i <= DEPTH; i++) begin
			compare_hex("adr_o", beat_q[i], addr_t'(32'h4000 + i * 16));
		end
		// the last pop lands at the edge of the last completion
		@(posedge clk_i);
		check_true(!p0_hit_o, "hit still reported after the buffer drained");
		check_true(!p1_hit_o, "port 1 hit still reported after the buffer drained");
		check_true(!cyc_o, "bus cycle still open after the buffer drained");
		compare_memory();
		close_test("back-pressure and hits", err_before);
	endtask

	// a faulted head store takes the two stores queued behind it along
	task automatic test_fault(string name, int kind, fault_e code, addr_t base, tag_t tag0);
		store_req_t s;
		int err_before;
		err_before = errors;
		beat_q.delete();
		@(posedge clk_i);
		bus_busy_i <= 1'b1;
		for (int i = 0; i < 3; i++) begin
			s = new_store(tag_t'(tag0 + i), addr_t'(base + i * 16), 8'hff);
			@(posedge clk_i);
			raise_request(0, s);
			await_ack(0, s);
		end
		inject_kind = kind;
		@(posedge clk_i);
		bus_busy_i <= 1'b0;
		check_next_completion(1'b0, code);
		exp_q.delete();
		repeat (8) @(posedge clk_i);
		compare_hex("beat count", beat_q.size(), 1);
		check_true(comp_q.size() == 0, "a store behind the faulted one still completed");
		compare_hex("fault_o", fault_o, code);
		// acceptance stays off until wb_en_i pulses
		s = new_store(tag_t'(tag0 + 3), addr_t'(base + 48), 8'hff);
		raise_request(0, s);
		no_ack_for(0, 6);
		wb_en_i <= 1'b1;
		@(posedge clk_i);
		wb_en_i <= 1'b0;
		await_ack(0, s);
		check_next_completion(1'b1, code);
		compare_hex("beat count", beat_q.size(), 2);
		if (beat_q.size() == 2) begin
			compare_hex("adr_o", beat_q[1], addr_t'(base + 48));
		end
		compare_memory();
		close_test(name, err_before);
	endtask

	// ==============================
	// run
	// ==============================

	initial begin
		void'($urandom(32'h2fa3));
		rst_i = 1'b1;
		p0_wr_i = 1'b0;
		p0_req_i = '0;
		p1_wr_i = 1'b0;
		p1_req_i = '0;
		p0_adr_i = '0;
		p1_adr_i = '0;
		wb_en_i = 1'b0;
		bus_busy_i = 1'b0;
		ack_i = 1'b0;
		err_i = 1'b0;
		tlbmiss_i = 1'b0;
		wrv_i = 1'b0;
		inject_kind = 0;
		beat_wait = 0;
		beat_lat = 1;
		cycle_count = 0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		repeat (3) @(posedge clk_i);
		rst_i <= 1'b0;
		@(posedge clk_i);
		test_aligned();
		test_line_cross();
		test_priority();
		test_backpressure();
		test_fault("tlb miss fault", 2, FLT_TLB, 32'h0000_6000, 4'h8);
		test_fault("bus error fault", 1, FLT_BUS, 32'h0000_7000, 4'hc);
		test_fault("write violation fault", 3, FLT_WRV, 32'h0000_8000, 4'h0);
		$display("%0d tests run, %0d failed, %0d check errors, %0d assertion failures",
			tests_run, tests_failed, errors, u_store_buffer.u_sva.fail_count);
		if (errors == 0 && tests_failed == 0 && u_store_buffer.u_sva.fail_count == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// ==== src/bus_store_engine.sv ====
module bus_store_engine (
	input logic clk_i,
	input logic rst_i,
	input logic head_valid_i,
	input store_pkg::store_req_t head_entry_i,
	input logic bus_busy_i,
	input logic ack_i,
	input logic err_i,
	input logic tlbmiss_i,
	input logic wrv_i,
	output logic pop_o,
	output logic flush_o,
	output logic cyc_o,
	output logic stb_o,
	output logic we_o,
	output store_pkg::bsel_t sel_o,
	output store_pkg::addr_t adr_o,
	output store_pkg::bdata_t dat_o,
	output logic update_o,
	output store_pkg::tag_t commit_tag_o,
	output logic cwr_o,
	output store_pkg::cache_wr_t cache_wr_o,
	output store_pkg::fault_e fault_o
);
	import store_pkg::*;

	typedef enum logic [1:0] {
		IDLE = 2'd0,
		BEAT1 = 2'd1,
		GAP = 2'd2,
		BEAT2 = 2'd3
	} state_e;

	state_e state_q;

	// select and data placed at their byte lanes over two lines
	logic [31:0] sel_wide;
	logic [255:0] dat_wide;
	logic [31:0] sel_shift;
	logic [255:0] dat_shift;

	logic start;
	logic resp;
	logic bad;
	logic finish;
	fault_e flt_code;

	// the head entry stays put until our own pop or flush reaches the queue
	// so it is read directly while the store is in flight
	assign sel_wide = {24'd0, head_entry_i.sel} << head_entry_i.addr[3:0];
	assign dat_wide = {192'd0, head_entry_i.data} << {head_entry_i.addr[3:0], 3'b000};

	// do not restart while a pop or flush is still on its way to the queue,
	// and let a lingering ack from the last beat fall first
	assign start = (state_q == IDLE) && head_valid_i && !pop_o && !flush_o
		&& !bus_busy_i && !ack_i;

	// any of these ends the current beat
	assign resp = ack_i || err_i || tlbmiss_i || wrv_i;
	assign bad = err_i || tlbmiss_i || wrv_i;

	// a store ends on the final beat or on the first error
	assign finish = resp && ((state_q == BEAT2)
		|| (state_q == BEAT1 && (bad || sel_shift[31:16] == 16'h0000)));

	// tlb miss wins over write violation which wins over bus error
	assign flt_code = tlbmiss_i ? FLT_TLB : wrv_i ? FLT_WRV : FLT_BUS;

	// ==============================
	// bus sequencing
	// ==============================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q <= IDLE;
			cyc_o <= 1'b0;
			stb_o <= 1'b0;
			we_o <= 1'b0;
			sel_o <= '0;
			update_o <= 1'b0;
			pop_o <= 1'b0;
			flush_o <= 1'b0;
			cwr_o <= 1'b0;
			fault_o <= FLT_NONE;
		end else begin
			// completion strobes last a single cycle
			update_o <= 1'b0;
			pop_o <= 1'b0;
			flush_o <= 1'b0;
			cwr_o <= 1'b0;
			case (state_q)
				IDLE: begin
					if (start) begin
						state_q <= BEAT1;
						cyc_o <= 1'b1;
						stb_o <= 1'b1;
						we_o <= 1'b1;
						sel_o <= sel_wide[15:0];
					end
				end
				BEAT1: begin
					if (resp) begin
						stb_o <= 1'b0;
						if (!finish) begin
							state_q <= GAP;
						end
					end
				end
				GAP: begin
					// the slave must drop ack before the second strobe
					if (!ack_i) begin
						state_q <= BEAT2;
						stb_o <= 1'b1;
						sel_o <= sel_shift[31:16];
					end
				end
				default: begin
				end
			endcase
			if (finish) begin
				state_q <= IDLE;
				cyc_o <= 1'b0;
				stb_o <= 1'b0;
				we_o <= 1'b0;
				sel_o <= '0;
				update_o <= 1'b1;
				if (bad) begin
					// the whole buffer goes and the arbiter stops accepting
					flush_o <= 1'b1;
					fault_o <= flt_code;
				end else begin
					pop_o <= 1'b1;
					cwr_o <= 1'b1;
				end
			end
		end
	end

	// ==============================
	// beat payload and results
	// ==============================

	always_ff @(posedge clk_i) begin
		if (start) begin
			sel_shift <= sel_wide;
			dat_shift <= dat_wide;
			// beat one always goes to the line holding the first byte
			adr_o <= {line_of(head_entry_i.addr), 4'h0};
			dat_o <= dat_wide[127:0];
		end
		if (state_q == GAP && !ack_i) begin
			// beat two carries the spill into the next line
			adr_o <= {adr_o[31:4] + 28'd1, 4'h0};
			dat_o <= dat_shift[255:128];
		end
		if (finish) begin
			commit_tag_o <= head_entry_i.tag;
			cache_wr_o <= '{sel: head_entry_i.sel, addr: head_entry_i.addr,
				data: head_entry_i.data};
		end
	end

endmodule

// ==== src/store_buffer.sv ====
module store_buffer #(
	parameter int DEPTH = 7
) (
	input logic clk_i,
	input logic rst_i,
	// store ports from the issue stage
	input logic p0_wr_i,
	input store_pkg::store_req_t p0_req_i,
	output logic p0_ack_o,
	input logic p1_wr_i,
	input store_pkg::store_req_t p1_req_i,
	output logic p1_ack_o,
	// load hit queries
	input store_pkg::addr_t p0_adr_i,
	input store_pkg::addr_t p1_adr_i,
	output logic p0_hit_o,
	output logic p1_hit_o,
	input logic wb_en_i,
	// bus master side
	input logic bus_busy_i,
	output logic cyc_o,
	output logic stb_o,
	output logic we_o,
	output store_pkg::bsel_t sel_o,
	output store_pkg::addr_t adr_o,
	output store_pkg::bdata_t dat_o,
	input logic ack_i,
	input logic err_i,
	input logic tlbmiss_i,
	input logic wrv_i,
	// completion reports
	output logic update_o,
	output store_pkg::tag_t commit_tag_o,
	output logic cwr_o,
	output store_pkg::cache_wr_t cache_wr_o,
	output store_pkg::fault_e fault_o
);
	import store_pkg::*;

	logic push;
	store_req_t push_entry;
	logic full;
	logic head_valid;
	store_req_t head_entry;
	logic pop;
	// one fault flush clears the queue and the arbiter's enable
	logic flush;

	store_port_arbiter u_arbiter (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.p0_wr_i(p0_wr_i),
		.p0_req_i(p0_req_i),
		.p1_wr_i(p1_wr_i),
		.p1_req_i(p1_req_i),
		.full_i(full),
		.flush_i(flush),
		.wb_en_i(wb_en_i),
		.p0_ack_o(p0_ack_o),
		.p1_ack_o(p1_ack_o),
		.push_o(push),
		.push_entry_o(push_entry)
	);

	write_buffer_queue #(
		.DEPTH(DEPTH)
	) u_queue (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.push_i(push),
		.push_entry_i(push_entry),
		.pop_i(pop),
		.flush_i(flush),
		.p0_adr_i(p0_adr_i),
		.p1_adr_i(p1_adr_i),
		.full_o(full),
		.head_valid_o(head_valid),
		.head_entry_o(head_entry),
		.p0_hit_o(p0_hit_o),
		.p1_hit_o(p1_hit_o)
	);

	bus_store_engine u_engine (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.head_valid_i(head_valid),
		.head_entry_i(head_entry),
		.bus_busy_i(bus_busy_i),
		.ack_i(ack_i),
		.err_i(err_i),
		.tlbmiss_i(tlbmiss_i),
		.wrv_i(wrv_i),
		.pop_o(pop),
		.flush_o(flush),
		.cyc_o(cyc_o),
		.stb_o(stb_o),
		.we_o(we_o),
		.sel_o(sel_o),
		.adr_o(adr_o),
		.dat_o(dat_o),
		.update_o(update_o),
		.commit_tag_o(commit_tag_o),
		.cwr_o(cwr_o),
		.cache_wr_o(cache_wr_o),
		.fault_o(fault_o)
	);

endmodule

// ==== src/store_pkg.sv ====
package store_pkg;

	// ==============================
	// widths that carry a meaning
	// ==============================

	// byte address as seen by the store path
	typedef logic [31:0] addr_t;
	// the upper 28 bits of an address name one 16-byte line
	typedef logic [27:0] line_t;
	// a single store moves up to eight bytes
	typedef logic [63:0] sdata_t;
	typedef logic [7:0] ssel_t;
	// the bus is one full line wide
	typedef logic [127:0] bdata_t;
	typedef logic [15:0] bsel_t;
	// commit tag names the issue-queue slot that owns the store
	typedef logic [3:0] tag_t;

	// one store as a port offers it and as the buffer holds it
	typedef struct packed {
		tag_t tag;
		ssel_t sel;
		addr_t addr;
		sdata_t data;
	} store_req_t;

	// fault codes reported when a store ends badly
	typedef enum logic [1:0] {
		FLT_NONE = 2'd0,
		FLT_BUS = 2'd1,
		FLT_TLB = 2'd2,
		FLT_WRV = 2'd3
	} fault_e;

	// write-back of a completed store into the data cache
	typedef struct packed {
		ssel_t sel;
		addr_t addr;
		sdata_t data;
	} cache_wr_t;

	// line number of a byte address
	function automatic line_t line_of(addr_t adr);
		return adr[31:4];
	endfunction

endpackage

// ==== src/store_port_arbiter.sv ====
module store_port_arbiter (
	input logic clk_i,
	input logic rst_i,
	input logic p0_wr_i,
	input store_pkg::store_req_t p0_req_i,
	input logic p1_wr_i,
	input store_pkg::store_req_t p1_req_i,
	input logic full_i,
	input logic flush_i,
	input logic wb_en_i,
	output logic p0_ack_o,
	output logic p1_ack_o,
	output logic push_o,
	output store_pkg::store_req_t push_entry_o
);
	import store_pkg::*;

	// store acceptance flag, dropped by a fault and raised again by wb_en_i
	logic wb_en;
	logic p0_take;
	logic p1_take;
	logic accept;

	// a port whose ack is high right now has already been taken
	// and must not be captured a second time
	assign p0_take = p0_wr_i && !p0_ack_o;
	assign p1_take = p1_wr_i && !p1_ack_o;

	// full_i does not yet count a push that is still on its way into the queue
	// so nothing is taken while push_o is high
	// a flush in this cycle would also throw away whatever we push next
	assign accept = (p0_take || p1_take) && wb_en && !full_i && !push_o && !flush_i;

	// ==============================
	// control state
	// ==============================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wb_en <= 1'b1;
			p0_ack_o <= 1'b0;
			p1_ack_o <= 1'b0;
			push_o <= 1'b0;
		end else begin
			// the fault flush takes precedence over a re-enable in the same cycle
			if (flush_i) begin
				wb_en <= 1'b0;
			end else if (wb_en_i) begin
				wb_en <= 1'b1;
			end
			// p0 has fixed priority over p1
			p0_ack_o <= accept && p0_take;
			p1_ack_o <= accept && !p0_take;
			push_o <= accept;
		end
	end

	// ==============================
	// push payload
	// ==============================

	// only meaningful while push_o is high
	always_ff @(posedge clk_i) begin
		if (accept) begin
			push_entry_o <= p0_take ? p0_req_i : p1_req_i;
		end
	end

endmodule

// ==== src/write_buffer_queue.sv ====
module write_buffer_queue #(
	parameter int DEPTH = 7
) (
	input logic clk_i,
	input logic rst_i,
	input logic push_i,
	input store_pkg::store_req_t push_entry_i,
	input logic pop_i,
	input logic flush_i,
	input store_pkg::addr_t p0_adr_i,
	input store_pkg::addr_t p1_adr_i,
	output logic full_o,
	output logic head_valid_o,
	output store_pkg::store_req_t head_entry_o,
	output logic p0_hit_o,
	output logic p1_hit_o
);
	import store_pkg::*;

	// the count runs from 0 up to DEPTH inclusive
	localparam int CW = $clog2(DEPTH + 1);

	store_req_t entry_q [DEPTH];
	logic [DEPTH-1:0] valid_q;
	logic [CW-1:0] count_q;
	logic [CW-1:0] count_d;
	logic [CW-1:0] wr_idx;

	// ==============================
	// fill level
	// ==============================

	// a push and a pop together leave the count where it is
	always_comb begin
		count_d = count_q;
		if (push_i && !pop_i) begin
			count_d = count_q + 1'b1;
		end else if (pop_i && !push_i) begin
			count_d = count_q - 1'b1;
		end
	end

	// the new entry lands behind the last valid one
	// when the queue shifts in the same cycle that slot moves down by one
	assign wr_idx = pop_i ? count_q - 1'b1 : count_q;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			count_q <= '0;
			valid_q <= '0;
		end else if (flush_i) begin
			// a fault drops every pending store, including one pushed right now
			count_q <= '0;
			valid_q <= '0;
		end else begin
			count_q <= count_d;
			// valid bits always form a run from the head up to the count
			for (int i = 0; i < DEPTH; i++) begin
				valid_q[i] <= (CW'(i) < count_d);
			end
		end
	end

	// ==============================
	// entry storage
	// ==============================

	// entries move toward the head on a pop
	// the push write comes second so it overrides the shifted value in its slot
	always_ff @(posedge clk_i) begin
		if (pop_i) begin
			for (int i = 0; i < DEPTH - 1; i++) begin
				entry_q[i] <= entry_q[i + 1];
			end
		end
		if (push_i) begin
			entry_q[wr_idx] <= push_entry_i;
		end
	end

	assign full_o = (count_q == CW'(DEPTH));
	assign head_valid_o = valid_q[0];
	assign head_entry_o = entry_q[0];

	// ==============================
	// load hit detection
	// ==============================

	// a load to any line that still has a buffered store must wait
	// until the buffer has written that store out
	// the head stays valid until its pop, so a store on the bus still hits
	always_comb begin
		p0_hit_o = 1'b0;
		p1_hit_o = 1'b0;
		for (int i = 0; i < DEPTH; i++) begin
			if (valid_q[i] && line_of(entry_q[i].addr) == line_of(p0_adr_i)) begin
				p0_hit_o = 1'b1;
			end
			if (valid_q[i] && line_of(entry_q[i].addr) == line_of(p1_adr_i)) begin
				p1_hit_o = 1'b1;
			end
		end
	end

endmodule

// ==== store_buffer.f ====
src/store_pkg.sv
src/store_port_arbiter.sv
src/write_buffer_queue.sv
src/bus_store_engine.sv
src/store_buffer.sv
dv/store_buffer_sva.sv
dv/store_buffer_tb.sv
